// ==== Makefile ====
# Verilator simulation of the UDP/IP transmit core

TOP       ?= tb_udp_ip_tx_64
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f

.PHONY: sim clean

# a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== source/axis64_pkg.sv ====
`default_nettype none

package axis64_pkg;

    localparam int DATA_BYTES = 8;

    typedef logic [8*DATA_BYTES-1:0] word_t;
    typedef logic [DATA_BYTES-1:0]   keep_t;
    typedef logic [3:0]              count_t;

    // keep must be contiguous from byte lane 0
    function automatic count_t keep_to_count(input keep_t keep);
        count_t count;
        count = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (keep[i]) begin
                count = count_t'(i + 1);
            end
        end
        return count;
    endfunction

    // low lanes enabled, count of 0 gives an empty keep
    function automatic keep_t count_to_keep(input count_t count);
        keep_t keep;
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep[i] = (i < int'(count));
        end
        return keep;
    endfunction

endpackage

`default_nettype wire

// ==== source/axis64_skid_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module axis64_skid_buffer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire axis64_pkg::word_t int_tdata,
    input  wire axis64_pkg::keep_t int_tkeep,
    input  wire                    int_tvalid,
    output logic                   int_ready,
    output logic                   int_ready_early,
    input  wire                    int_tlast,
    input  wire                    int_tuser,
    output axis64_pkg::word_t      m_tdata,
    output axis64_pkg::keep_t      m_tkeep,
    output logic                   m_tvalid,
    input  wire                    m_tready,
    output logic                   m_tlast,
    output logic                   m_tuser
);
    import axis64_pkg::*;

    word_t temp_tdata;
    keep_t temp_tkeep;
    logic  temp_tlast;
    logic  temp_tuser;
    logic  temp_tvalid;
    logic  m_tvalid_next;
    logic  temp_tvalid_next;
    logic  load_out_from_in;
    logic  load_temp_from_in;
    logic  load_out_from_temp;

    // stay ready unless temp could fill next cycle
    assign int_ready_early = m_tready | (~temp_tvalid & (~m_tvalid | ~int_tvalid));

    always_comb begin
        m_tvalid_next      = m_tvalid;
        temp_tvalid_next   = temp_tvalid;
        load_out_from_in   = 1'b0;
        load_temp_from_in  = 1'b0;
        load_out_from_temp = 1'b0;

        if (int_ready) begin
            if (m_tready || !m_tvalid) begin
                m_tvalid_next    = int_tvalid;
                load_out_from_in = 1'b1;
            end else begin
                temp_tvalid_next  = int_tvalid;
                load_temp_from_in = 1'b1;
            end
        end else if (m_tready) begin
            // drain temp into the output register
            m_tvalid_next      = temp_tvalid;
            temp_tvalid_next   = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid    <= 1'b0;
            temp_tvalid <= 1'b0;
            int_ready   <= 1'b0;
        end else begin
            m_tvalid    <= m_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
            int_ready   <= int_ready_early;
        end

        if (load_out_from_in) begin
            m_tdata <= int_tdata;
            m_tkeep <= int_tkeep;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (load_out_from_temp) begin
            m_tdata <= temp_tdata;
            m_tkeep <= temp_tkeep;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end

        if (load_temp_from_in) begin
            temp_tdata <= int_tdata;
            temp_tkeep <= int_tkeep;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    out_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
            && $stable(m_tlast) && $stable(m_tuser))
        else $error("output word changed while stalled");

endmodule

`default_nettype wire

// ==== source/udp_frame_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_frame_assembler (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      frame_start,
    input  wire udp_hdr_pkg::port_t  udp_src_port_q,
    input  wire udp_hdr_pkg::port_t  udp_dst_port_q,
    input  wire udp_hdr_pkg::len16_t udp_length_q,
    input  wire udp_hdr_pkg::csum_t  udp_checksum_q,
    input  wire axis64_pkg::word_t   s_tdata,
    input  wire axis64_pkg::keep_t   s_tkeep,
    input  wire                      s_tvalid,
    output logic                     s_tready,
    input  wire                      s_tlast,
    input  wire                      s_tuser,
    output logic                     frame_done,
    output logic                     err_early_term,
    output axis64_pkg::word_t        int_tdata,
    output axis64_pkg::keep_t        int_tkeep,
    output logic                     int_tvalid,
    output logic                     int_tlast,
    output logic                     int_tuser,
    input  wire                      int_ready,
    input  wire                      int_ready_early
);
    import udp_hdr_pkg::*;
    import axis64_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_write_header,
        st_write_payload,
        st_hold_last
    } state_t;

    state_t state;
    state_t state_next;
    len16_t frame_ptr;
    len16_t frame_ptr_next;
    len16_t ptr_sum;
    logic   s_tready_next;
    logic   early_term;
    logic   store_last;
    logic   in_xfer;
    word_t  held_tdata;
    keep_t  held_tkeep;

    // s_tready only rises along with int_ready, so a taken input word always fits
    assign in_xfer = s_tvalid & s_tready;
    assign ptr_sum = frame_ptr + len16_t'(keep_to_count(s_tkeep));

    always_comb begin
        state_next     = state;
        frame_ptr_next = frame_ptr;
        s_tready_next  = 1'b0;
        early_term     = 1'b0;
        store_last     = 1'b0;
        frame_done     = 1'b0;
        int_tdata      = s_tdata;
        int_tkeep      = s_tkeep;
        int_tvalid     = 1'b0;
        int_tlast      = s_tlast;
        int_tuser      = s_tuser;

        case (state)
            st_idle: begin
                if (frame_start) begin
                    state_next = st_write_header;
                end
            end
            st_write_header: begin
                // network byte order, first byte in lane 0
                int_tdata  = {udp_checksum_q[7:0], udp_checksum_q[15:8],
                              udp_length_q[7:0], udp_length_q[15:8],
                              udp_dst_port_q[7:0], udp_dst_port_q[15:8],
                              udp_src_port_q[7:0], udp_src_port_q[15:8]};
                int_tkeep  = '1;
                int_tlast  = 1'b0;
                int_tuser  = 1'b0;
                int_tvalid = int_ready;
                if (int_ready) begin
                    frame_ptr_next = UDP_HDR_BYTES;
                    s_tready_next  = int_ready_early;
                    state_next     = st_write_payload;
                end
            end
            st_write_payload: begin
                s_tready_next = int_ready_early;
                int_tvalid    = in_xfer;
                if (in_xfer) begin
                    if (ptr_sum >= udp_length_q) begin
                        // udp length reached inside this word
                        frame_ptr_next = udp_length_q;
                        int_tkeep      = count_to_keep(count_t'(udp_length_q - frame_ptr));
                        if (s_tlast) begin
                            frame_done    = 1'b1;
                            s_tready_next = 1'b0;
                            state_next    = st_idle;
                        end else begin
                            // input runs long, park the word until its tlast
                            store_last = 1'b1;
                            int_tvalid = 1'b0;
                            state_next = st_hold_last;
                        end
                    end else if (s_tlast) begin
                        // frame shorter than udp length
                        early_term    = 1'b1;
                        int_tuser     = 1'b1;
                        frame_done    = 1'b1;
                        s_tready_next = 1'b0;
                        state_next    = st_idle;
                    end else begin
                        frame_ptr_next = ptr_sum;
                    end
                end
            end
            st_hold_last: begin
                // discard input, release the parked word on tlast
                s_tready_next = int_ready_early;
                int_tdata     = held_tdata;
                int_tkeep     = held_tkeep;
                int_tlast     = 1'b1;
                int_tvalid    = in_xfer & s_tlast;
                if (in_xfer && s_tlast) begin
                    frame_done    = 1'b1;
                    s_tready_next = 1'b0;
                    state_next    = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= st_idle;
            frame_ptr      <= '0;
            s_tready       <= 1'b0;
            err_early_term <= 1'b0;
        end else begin
            state          <= state_next;
            frame_ptr      <= frame_ptr_next;
            s_tready       <= s_tready_next;
            err_early_term <= early_term;
        end

        if (store_last) begin
            held_tdata <= int_tdata;
            held_tkeep <= int_tkeep;
        end
    end

    // the skid buffer has no room for a word offered while int_ready is low
    int_valid_ready: assert property (@(posedge clk) disable iff (rst)
        int_tvalid |-> int_ready)
        else $error("word offered to the skid buffer while int_ready is low");

endmodule

`default_nettype wire

// ==== source/udp_hdr_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_hdr_capture (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          s_hdr_valid,
    output logic                         s_hdr_ready,
    input  wire udp_hdr_pkg::ident_t     ip_ident,
    input  wire udp_hdr_pkg::ttl_t       ip_ttl,
    input  wire udp_hdr_pkg::proto_t     ip_protocol,
    input  wire udp_hdr_pkg::ipv4_addr_t ip_src,
    input  wire udp_hdr_pkg::ipv4_addr_t ip_dst,
    input  wire udp_hdr_pkg::port_t      udp_src_port,
    input  wire udp_hdr_pkg::port_t      udp_dst_port,
    input  wire udp_hdr_pkg::len16_t     udp_length,
    input  wire udp_hdr_pkg::csum_t      udp_checksum,
    output logic                         m_hdr_valid,
    input  wire                          m_hdr_ready,
    output udp_hdr_pkg::len16_t          m_ip_length,
    output udp_hdr_pkg::ident_t          m_ip_ident,
    output udp_hdr_pkg::ttl_t            m_ip_ttl,
    output udp_hdr_pkg::proto_t          m_ip_protocol,
    output udp_hdr_pkg::ipv4_addr_t      m_ip_src,
    output udp_hdr_pkg::ipv4_addr_t      m_ip_dst,
    output logic                         frame_start,
    output udp_hdr_pkg::port_t           udp_src_port_q,
    output udp_hdr_pkg::port_t           udp_dst_port_q,
    output udp_hdr_pkg::len16_t          udp_length_q,
    output udp_hdr_pkg::csum_t           udp_checksum_q,
    input  wire                          frame_done,
    output logic                         busy
);
    import udp_hdr_pkg::*;

    logic frame_active;
    logic hdr_accept;

    assign hdr_accept  = s_hdr_valid & s_hdr_ready;
    assign frame_start = hdr_accept;
    assign busy        = frame_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_hdr_ready  <= 1'b0;
            m_hdr_valid  <= 1'b0;
            frame_active <= 1'b0;
        end else begin
            // next header only after the frame ends and the ip header is gone
            s_hdr_ready <= ~hdr_accept & ~frame_active & ~m_hdr_valid;

            if (hdr_accept) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end

            if (hdr_accept) begin
                frame_active <= 1'b1;
            end else if (frame_done) begin
                frame_active <= 1'b0;
            end
        end
    end

    // fields stay put for the whole frame
    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            m_ip_length    <= udp_length + IP_HDR_BYTES;
            m_ip_ident     <= ip_ident;
            m_ip_ttl       <= ip_ttl;
            m_ip_protocol  <= ip_protocol;
            m_ip_src       <= ip_src;
            m_ip_dst       <= ip_dst;
            udp_src_port_q <= udp_src_port;
            udp_dst_port_q <= udp_dst_port;
            udp_length_q   <= udp_length;
            udp_checksum_q <= udp_checksum;
        end
    end

    hdr_valid_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_ip_length))
        else $error("m_hdr_valid dropped before the ip header was taken");

endmodule

`default_nettype wire

// ==== source/udp_hdr_pkg.sv ====
`default_nettype none

package udp_hdr_pkg;

    // udp header fields
    typedef logic [15:0] port_t;
    typedef logic [15:0] len16_t;
    typedef logic [15:0] csum_t;

    // ip header fields that pass through
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [7:0]  ttl_t;
    typedef logic [7:0]  proto_t;
    typedef logic [15:0] ident_t;

    // udp header size, also the first payload pointer value
    localparam len16_t UDP_HDR_BYTES = 16'd8;

    // ip header without options
    localparam len16_t IP_HDR_BYTES = 16'd20;

endpackage

`default_nettype wire

// ==== source/udp_ip_tx_64.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_ip_tx_64 (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          s_hdr_valid,
    output wire                          s_hdr_ready,
    input  wire udp_hdr_pkg::ident_t     ip_ident,
    input  wire udp_hdr_pkg::ttl_t       ip_ttl,
    input  wire udp_hdr_pkg::proto_t     ip_protocol,
    input  wire udp_hdr_pkg::ipv4_addr_t ip_src,
    input  wire udp_hdr_pkg::ipv4_addr_t ip_dst,
    input  wire udp_hdr_pkg::port_t      udp_src_port,
    input  wire udp_hdr_pkg::port_t      udp_dst_port,
    input  wire udp_hdr_pkg::len16_t     udp_length,
    input  wire udp_hdr_pkg::csum_t      udp_checksum,
    input  wire axis64_pkg::word_t       s_tdata,
    input  wire axis64_pkg::keep_t       s_tkeep,
    input  wire                          s_tvalid,
    output wire                          s_tready,
    input  wire                          s_tlast,
    input  wire                          s_tuser,
    output wire                          m_hdr_valid,
    input  wire                          m_hdr_ready,
    output wire udp_hdr_pkg::len16_t     m_ip_length,
    output wire udp_hdr_pkg::ident_t     m_ip_ident,
    output wire udp_hdr_pkg::ttl_t       m_ip_ttl,
    output wire udp_hdr_pkg::proto_t     m_ip_protocol,
    output wire udp_hdr_pkg::ipv4_addr_t m_ip_src,
    output wire udp_hdr_pkg::ipv4_addr_t m_ip_dst,
    output wire axis64_pkg::word_t       m_tdata,
    output wire axis64_pkg::keep_t       m_tkeep,
    output wire                          m_tvalid,
    input  wire                          m_tready,
    output wire                          m_tlast,
    output wire                          m_tuser,
    output wire                          busy,
    output wire                          err_early_term
);
    import udp_hdr_pkg::*;
    import axis64_pkg::*;

    // header capture to assembler
    wire         frame_start;
    wire         frame_done;
    wire port_t  udp_src_port_q;
    wire port_t  udp_dst_port_q;
    wire len16_t udp_length_q;
    wire csum_t  udp_checksum_q;

    // assembler to output skid
    wire word_t  int_tdata;
    wire keep_t  int_tkeep;
    wire         int_tvalid;
    wire         int_tlast;
    wire         int_tuser;
    wire         int_ready;
    wire         int_ready_early;

    udp_hdr_capture u_hdr_capture (.*);

    udp_frame_assembler u_frame_assembler (.*);

    axis64_skid_buffer u_skid_buffer (.*);

endmodule

`default_nettype wire

// ==== tb/tb_udp_ip_tx_64.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_udp_ip_tx_64;
    import udp_hdr_pkg::*;
    import axis64_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int WAIT_TIMEOUT  = 300;
    localparam int DRAIN_TIMEOUT = 3000;
    localparam int NUM_FRAMES    = 24;
    localparam int unsigned SEED = 32'h48c4;
    localparam int KIND_EXACT    = 0;
    localparam int KIND_LONG     = 1;
    localparam int KIND_EARLY    = 2;

    logic clk = 1'b0;
    logic rst;
    logic s_hdr_valid, s_hdr_ready, m_hdr_valid, m_hdr_ready;
    ident_t ip_ident, m_ip_ident;
    ttl_t ip_ttl, m_ip_ttl;
    proto_t ip_protocol, m_ip_protocol;
    ipv4_addr_t ip_src, ip_dst, m_ip_src, m_ip_dst;
    port_t udp_src_port, udp_dst_port;
    len16_t udp_length, m_ip_length;
    csum_t udp_checksum;
    word_t s_tdata, m_tdata;
    keep_t s_tkeep, m_tkeep;
    logic s_tvalid, s_tready, s_tlast, s_tuser;
    logic m_tvalid, m_tready, m_tlast, m_tuser;
    logic busy, err_early_term;

    // reference model state
    word_t in_data[$];
    keep_t in_keep[$];
    logic [73:0] exp_words[$];
    logic [111:0] exp_hdr[$];
    logic [111:0] hdr_now;
    logic [73:0] word_now;
    logic random_bp = 1'b0;
    logic cur_early = 1'b0;
    logic exp_busy;
    logic exp_err;
    int early_expected = 0;
    int early_seen = 0;

    udp_ip_tx_64 uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                   input logic [63:0] act);
        abort_run($sformatf("[FAIL] time %0t: %s expected %h, got %h", $time, sig, exp, act));
    endtask

    task automatic check_field(input string sig, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else report_mismatch(sig, exp, act);
    endtask

    function automatic keep_t low_lanes(input int n);
        return keep_t'((16'd1 << n) - 16'd1);
    endfunction

    function automatic word_t byte_mask(input keep_t keep);
        word_t m;
        for (int i = 0; i < DATA_BYTES; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    // payload of the given kind with full words except the last
    task automatic build_frame(input int kind, input int udp_len);
        int remain;
        int n;
        in_data.delete();
        in_keep.delete();
        case (kind)
            KIND_LONG:  remain = udp_len - 7 + int'($urandom % 32'd20);
            KIND_EARLY: remain = 1 + int'($urandom % 32'(udp_len - 9));
            default:    remain = udp_len - 8;
        endcase
        while (remain > 0) begin
            n = (remain > DATA_BYTES) ? DATA_BYTES : remain;
            in_data.push_back({$urandom, $urandom});
            in_keep.push_back(low_lanes(n));
            remain = remain - n;
        end
    endtask

    // expected output is the udp header word and then the payload cut at the udp length
    task automatic expect_frame(input int udp_len);
        word_t hw;
        int remain;
        int cnt;
        logic last;
        logic done;
        hw[7:0]   = udp_src_port[15:8];
        hw[15:8]  = udp_src_port[7:0];
        hw[23:16] = udp_dst_port[15:8];
        hw[31:24] = udp_dst_port[7:0];
        hw[39:32] = udp_length[15:8];
        hw[47:40] = udp_length[7:0];
        hw[55:48] = udp_checksum[15:8];
        hw[63:56] = udp_checksum[7:0];
        exp_words.push_back({1'b0, 1'b0, 8'hff, hw});
        remain = udp_len - 8;
        done = 1'b0;
        for (int i = 0; i < in_data.size(); i++) begin
            cnt = $countones(in_keep[i]);
            last = (i == in_data.size() - 1);
            if (!done && cnt >= remain) begin
                exp_words.push_back({1'b1, 1'b0, low_lanes(remain), in_data[i]});
                done = 1'b1;
            end else if (!done && last) begin
                exp_words.push_back({1'b1, 1'b1, in_keep[i], in_data[i]});
                early_expected++;
            end else if (!done) begin
                exp_words.push_back({1'b0, 1'b0, in_keep[i], in_data[i]});
                remain = remain - cnt;
            end
        end
    endtask

    task automatic send_header();
        int waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        s_hdr_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = s_hdr_ready;
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            if (waited > WAIT_TIMEOUT) begin
                abort_run("timeout: the udp header was never accepted");
            end
        end
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        int waited;
        logic taken;
        for (int i = 0; i < in_data.size(); i++) begin
            if ($urandom % 4 == 0) begin
                // idle gap on the input stream
                s_tvalid = 1'b0;
                @(posedge clk);
                #DRIVE_DELAY;
            end
            s_tvalid = 1'b1;
            s_tdata  = in_data[i];
            s_tkeep  = in_keep[i];
            s_tlast  = (i == in_data.size() - 1);
            waited = 0;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = s_tready;
                @(posedge clk);
                #DRIVE_DELAY;
                waited++;
                if (waited > WAIT_TIMEOUT) begin
                    abort_run("timeout: a payload word was never accepted");
                end
            end
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // output back-pressure
    always @(posedge clk) begin
        #DRIVE_DELAY;
        m_tready    = random_bp ? ($urandom % 4 != 0) : 1'b1;
        m_hdr_ready = random_bp ? ($urandom % 3 == 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_busy <= 1'b0;
            exp_err  <= 1'b0;
        end else begin
            if (s_hdr_valid && s_hdr_ready) begin
                exp_busy <= 1'b1;
            end else if (s_tvalid && s_tready && s_tlast) begin
                exp_busy <= 1'b0;
            end
            exp_err <= s_tvalid && s_tready && s_tlast && cur_early;
            if (err_early_term) begin
                early_seen <= early_seen + 1;
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && m_tvalid && m_tready) begin
            if (exp_words.size() == 0) begin
                abort_run("an output word appeared with none expected");
            end
            word_now = exp_words.pop_front();
            check_field("m_tkeep", 64'(word_now[71:64]), 64'(m_tkeep));
            check_field("m_tdata", word_now[63:0] & byte_mask(word_now[71:64]),
                        m_tdata & byte_mask(word_now[71:64]));
            check_field("m_tlast", 64'(word_now[73]), 64'(m_tlast));
            check_field("m_tuser", 64'(word_now[72]), 64'(m_tuser));
        end
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            if (exp_hdr.size() == 0) begin
                abort_run("an ip header appeared with none expected");
            end
            hdr_now = exp_hdr.pop_front();
            check_field("m_ip_length", 64'(hdr_now[111:96]), 64'(m_ip_length));
            check_field("m_ip_ident", 64'(hdr_now[95:80]), 64'(m_ip_ident));
            check_field("m_ip_ttl", 64'(hdr_now[79:72]), 64'(m_ip_ttl));
            check_field("m_ip_protocol", 64'(hdr_now[71:64]), 64'(m_ip_protocol));
            check_field("m_ip_src/m_ip_dst", hdr_now[63:0], {m_ip_src, m_ip_dst});
        end
    end

    ip_hdr_held: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_ip_length) && $stable(m_ip_src))
        else abort_run("m_hdr_valid or the ip header changed before it was taken");

    out_word_held: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep))
        else abort_run("the output word changed while m_tready was low");

    busy_matches: assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
        else report_mismatch("busy", 64'($sampled(exp_busy)), 64'($sampled(busy)));

    early_term_pulse: assert property (@(posedge clk) disable iff (rst) err_early_term == exp_err)
        else report_mismatch("err_early_term", 64'($sampled(exp_err)),
                             64'($sampled(err_early_term)));

    initial begin
        int kind;
        int udp_len;
        int waited;
        void'($urandom(SEED));
        rst = 1'b1;
        s_hdr_valid = 1'b0;
        ip_ident = '0;
        ip_ttl = '0;
        ip_protocol = '0;
        ip_src = '0;
        ip_dst = '0;
        udp_src_port = '0;
        udp_dst_port = '0;
        udp_length = '0;
        udp_checksum = '0;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        m_tready = 1'b0;
        m_hdr_ready = 1'b0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_field("s_hdr_ready", 64'd0, 64'(s_hdr_ready));
        check_field("s_tready", 64'd0, 64'(s_tready));
        check_field("m_hdr_valid", 64'd0, 64'(m_hdr_valid));
        check_field("m_tvalid", 64'd0, 64'(m_tvalid));
        check_field("busy", 64'd0, 64'(busy));
        check_field("err_early_term", 64'd0, 64'(err_early_term));
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // directed kinds first and random kinds under back-pressure after them
        for (int f = 0; f < NUM_FRAMES; f++) begin
            kind = (f == 2) ? KIND_LONG : (f == 3) ? KIND_EARLY :
                   (f < 5) ? KIND_EXACT : int'($urandom % 32'd3);
            udp_len = (f == 0) ? 32 : 10 + int'($urandom % 32'd55);
            random_bp = (f >= 5);
            ip_ident = ident_t'($urandom);
            ip_ttl = ttl_t'($urandom);
            ip_protocol = proto_t'($urandom);
            ip_src = $urandom;
            ip_dst = $urandom;
            udp_src_port = port_t'($urandom);
            udp_dst_port = port_t'($urandom);
            udp_length = len16_t'(udp_len);
            udp_checksum = csum_t'($urandom);
            exp_hdr.push_back({len16_t'(udp_len + 20), ip_ident, ip_ttl, ip_protocol,
                               ip_src, ip_dst});
            build_frame(kind, udp_len);
            expect_frame(udp_len);
            cur_early = (kind == KIND_EARLY);
            send_header();
            send_payload();
        end

        waited = 0;
        while (exp_words.size() != 0 || exp_hdr.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timeout: expected output words never appeared");
            end
        end
        @(negedge clk);

        if (early_seen == early_expected) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("err_early_term pulsed %0d times, expected %0d",
                                early_seen, early_expected));
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/udp_hdr_pkg.sv
source/axis64_pkg.sv
source/udp_hdr_capture.sv
source/udp_frame_assembler.sv
source/axis64_skid_buffer.sv
source/udp_ip_tx_64.sv
tb/tb_udp_ip_tx_64.sv
